/* Makefile */
SRCS := $(shell cat vlog.f)

all: run

obj_dir/Vtb_axi_mem_subsys: vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module tb_axi_mem_subsys -Mdir obj_dir

run: obj_dir/Vtb_axi_mem_subsys
	@out="$$(./obj_dir/Vtb_axi_mem_subsys)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

.PHONY: all run clean

/* axi_bank_decoder.sv */
// steers AW, W and AR valids to the addressed bank and returns that bank's readies
`timescale 1ns/10ps
`default_nettype none

module axi_bank_decoder (
  input  wire  [axi_sys_pkg::ADDR_WIDTH-1:0] i_awaddr,
  input  wire                                i_awvalid,
  output logic                               o_awready,
  input  wire                                i_wvalid,
  output logic                               o_wready,
  input  wire  [axi_sys_pkg::ADDR_WIDTH-1:0] i_araddr,
  input  wire                                i_arvalid,
  output logic                               o_arready,
  output logic [axi_sys_pkg::NUM_BANKS-1:0]  o_bank_awvalid,
  output logic [axi_sys_pkg::NUM_BANKS-1:0]  o_bank_wvalid,
  output logic [axi_sys_pkg::NUM_BANKS-1:0]  o_bank_arvalid,
  input  wire  [axi_sys_pkg::NUM_BANKS-1:0]  i_bank_awready,
  input  wire  [axi_sys_pkg::NUM_BANKS-1:0]  i_bank_wready,
  input  wire  [axi_sys_pkg::NUM_BANKS-1:0]  i_bank_arready
);

  logic [axi_sys_pkg::BANK_SEL_WIDTH-1:0] aw_sel;  // W rides on the AW index
  logic [axi_sys_pkg::BANK_SEL_WIDTH-1:0] ar_sel;

  assign aw_sel = i_awaddr[axi_sys_pkg::BANK_SEL_LSB +: axi_sys_pkg::BANK_SEL_WIDTH];
  assign ar_sel = i_araddr[axi_sys_pkg::BANK_SEL_LSB +: axi_sys_pkg::BANK_SEL_WIDTH];

  // --------------------------------------------------
  // valid steering
  // --------------------------------------------------
  always_comb begin
    o_bank_awvalid         = '0;
    o_bank_wvalid          = '0;
    o_bank_arvalid         = '0;
    o_bank_awvalid[aw_sel] = i_awvalid;
    o_bank_wvalid[aw_sel]  = i_wvalid;
    o_bank_arvalid[ar_sel] = i_arvalid;
  end

  // ready return from the selected bank
  assign o_awready = i_bank_awready[aw_sel];
  assign o_wready  = i_bank_wready[aw_sel];
  assign o_arready = i_bank_arready[ar_sel];

endmodule

`default_nettype wire

/* axi_master_bridge.sv */
// client request port to single-beat AXI master; one transaction in flight at a time
`timescale 1ns/10ps
`default_nettype none

module axi_master_bridge (
  input  wire                                   i_aclk,
  input  wire                                   i_reset,
  // client side
  input  wire                                   i_rw_req,
  input  wire                                   i_rw_wr,
  input  wire  [axi_sys_pkg::ADDR_WIDTH-1:0]    i_rw_addr,
  input  wire  [axi_sys_pkg::STRB_WIDTH-1:0]    i_rw_wstrb,
  input  wire  [axi_sys_pkg::DATA_WIDTH-1:0]    i_rw_wdata,
  output logic                                  o_rw_addr_ok,
  output logic                                  o_rw_data_ok,
  output logic [axi_sys_pkg::DATA_WIDTH-1:0]    o_rw_rdata,
  output logic                                  o_rw_err,
  // write address / data
  output logic [axi_sys_pkg::ADDR_WIDTH-1:0]    o_awaddr,
  output logic                                  o_awvalid,
  input  wire                                   i_awready,
  output logic [axi_sys_pkg::DATA_WIDTH-1:0]    o_wdata,
  output logic [axi_sys_pkg::STRB_WIDTH-1:0]    o_wstrb,
  output logic                                  o_wvalid,
  input  wire                                   i_wready,
  // write response
  input  wire  [1:0]                            i_bresp,
  input  wire                                   i_bvalid,
  output logic                                  o_bready,
  // read address / data
  output logic [axi_sys_pkg::ADDR_WIDTH-1:0]    o_araddr,
  output logic                                  o_arvalid,
  input  wire                                   i_arready,
  input  wire  [axi_sys_pkg::DATA_WIDTH-1:0]    i_rdata,
  input  wire  [1:0]                            i_rresp,
  input  wire                                   i_rvalid,
  output logic                                  o_rready
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WADDR,  // AW and W outstanding
    ST_WRESP,
    ST_RADDR,
    ST_RDATA
  } state_t;

  state_t                            state_q;
  logic                              aw_done_q;  // AW accepted, W may still be pending
  logic                              w_done_q;
  logic [axi_sys_pkg::ADDR_WIDTH-1:0] addr_q;
  logic [axi_sys_pkg::STRB_WIDTH-1:0] strb_q;
  logic [axi_sys_pkg::DATA_WIDTH-1:0] wdata_q;

  wire accept  = (state_q == ST_IDLE) && i_rw_req;
  wire aw_fire = o_awvalid && i_awready;
  wire w_fire  = o_wvalid && i_wready;
  wire b_fire  = o_bready && i_bvalid;
  wire ar_fire = o_arvalid && i_arready;
  wire r_fire  = o_rready && i_rvalid;
  wire aw_ok   = aw_done_q || aw_fire;
  wire w_ok    = w_done_q || w_fire;

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_rw_req) begin
            state_q <= i_rw_wr ? ST_WADDR : ST_RADDR;
          end
        end
        ST_WADDR: begin
          if (aw_ok && w_ok) begin
            state_q   <= ST_WRESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_ok;  // remember whichever half went first
            w_done_q  <= w_ok;
          end
        end
        ST_WRESP: if (b_fire) state_q <= ST_IDLE;
        ST_RADDR: if (ar_fire) state_q <= ST_RDATA;
        ST_RDATA: if (r_fire) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // request capture
  always_ff @(posedge i_aclk) begin
    if (accept) begin
      addr_q  <= i_rw_addr;
      strb_q  <= i_rw_wstrb;
      wdata_q <= i_rw_wdata;
    end
  end

  // --------------------------------------------------
  // AXI channel drive
  // --------------------------------------------------
  assign o_awaddr  = addr_q;
  assign o_awvalid = (state_q == ST_WADDR) && !aw_done_q;
  assign o_wdata   = wdata_q;
  assign o_wstrb   = strb_q;
  assign o_wvalid  = (state_q == ST_WADDR) && !w_done_q;
  assign o_bready  = (state_q == ST_WRESP);
  assign o_araddr  = addr_q;
  assign o_arvalid = (state_q == ST_RADDR);
  assign o_rready  = (state_q == ST_RDATA);

  // client handshake
  assign o_rw_addr_ok = accept;
  assign o_rw_data_ok = b_fire || r_fire;
  assign o_rw_rdata   = i_rdata;                   // valid with data_ok on reads
  assign o_rw_err     = (state_q == ST_RDATA) ? (i_rresp != axi_sys_pkg::RESP_OKAY)
                                              : (i_bresp != axi_sys_pkg::RESP_OKAY);

endmodule

`default_nettype wire

/* axi_mem_subsys.sv */
// memory subsystem top: bridge, bank decoder, interleaved SRAM banks and response merge
`timescale 1ns/10ps
`default_nettype none

module axi_mem_subsys (
  input  wire                                i_aclk,
  input  wire                                i_reset,
  input  wire                                i_rw_req,
  input  wire                                i_rw_wr,
  input  wire  [axi_sys_pkg::ADDR_WIDTH-1:0] i_rw_addr,
  input  wire  [axi_sys_pkg::STRB_WIDTH-1:0] i_rw_wstrb,
  input  wire  [axi_sys_pkg::DATA_WIDTH-1:0] i_rw_wdata,
  output logic                               o_rw_addr_ok,
  output logic                               o_rw_data_ok,
  output logic [axi_sys_pkg::DATA_WIDTH-1:0] o_rw_rdata,
  output logic                               o_rw_err
);

  // --------------------------------------------------
  // bridge side channels
  // --------------------------------------------------
  wire [axi_sys_pkg::ADDR_WIDTH-1:0] awaddr;
  wire                               awvalid;
  wire                               awready;
  wire [axi_sys_pkg::DATA_WIDTH-1:0] wdata;
  wire [axi_sys_pkg::STRB_WIDTH-1:0] wstrb;
  wire                               wvalid;
  wire                               wready;
  wire                               bready;
  wire [axi_sys_pkg::ADDR_WIDTH-1:0] araddr;
  wire                               arvalid;
  wire                               arready;
  wire                               rready;
  wire                               bvalid;
  wire                               rvalid;
  wire axi_sys_pkg::b_payload_t      b_merged;
  wire axi_sys_pkg::r_payload_t      r_merged;

  // per-bank vectors
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_awvalid;
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_wvalid;
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_arvalid;
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_awready;
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_wready;
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_arready;
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_bvalid;
  wire [axi_sys_pkg::NUM_BANKS-1:0] bank_rvalid;
  wire axi_sys_pkg::b_payload_t [axi_sys_pkg::NUM_BANKS-1:0] bank_b;
  wire axi_sys_pkg::r_payload_t [axi_sys_pkg::NUM_BANKS-1:0] bank_r;

  axi_master_bridge u_bridge (
    .i_aclk       (i_aclk),
    .i_reset      (i_reset),
    .i_rw_req     (i_rw_req),
    .i_rw_wr      (i_rw_wr),
    .i_rw_addr    (i_rw_addr),
    .i_rw_wstrb   (i_rw_wstrb),
    .i_rw_wdata   (i_rw_wdata),
    .o_rw_addr_ok (o_rw_addr_ok),
    .o_rw_data_ok (o_rw_data_ok),
    .o_rw_rdata   (o_rw_rdata),
    .o_rw_err     (o_rw_err),
    .o_awaddr     (awaddr),
    .o_awvalid    (awvalid),
    .i_awready    (awready),
    .o_wdata      (wdata),
    .o_wstrb      (wstrb),
    .o_wvalid     (wvalid),
    .i_wready     (wready),
    .i_bresp      (b_merged.resp),
    .i_bvalid     (bvalid),
    .o_bready     (bready),
    .o_araddr     (araddr),
    .o_arvalid    (arvalid),
    .i_arready    (arready),
    .i_rdata      (r_merged.data),
    .i_rresp      (r_merged.resp),
    .i_rvalid     (rvalid),
    .o_rready     (rready)
  );

  axi_bank_decoder u_decoder (
    .i_awaddr       (awaddr),
    .i_awvalid      (awvalid),
    .o_awready      (awready),
    .i_wvalid       (wvalid),
    .o_wready       (wready),
    .i_araddr       (araddr),
    .i_arvalid      (arvalid),
    .o_arready      (arready),
    .o_bank_awvalid (bank_awvalid),
    .o_bank_wvalid  (bank_wvalid),
    .o_bank_arvalid (bank_arvalid),
    .i_bank_awready (bank_awready),
    .i_bank_wready  (bank_wready),
    .i_bank_arready (bank_arready)
  );

  // --------------------------------------------------
  // banks, address and data broadcast
  // --------------------------------------------------
  for (genvar g = 0; g < axi_sys_pkg::NUM_BANKS; g++) begin : g_bank
    axi_sram_bank u_bank (
      .i_aclk    (i_aclk),
      .i_reset   (i_reset),
      .i_awaddr  (awaddr),
      .i_awvalid (bank_awvalid[g]),
      .o_awready (bank_awready[g]),
      .i_wdata   (wdata),
      .i_wstrb   (wstrb),
      .i_wvalid  (bank_wvalid[g]),
      .o_wready  (bank_wready[g]),
      .o_bvalid  (bank_bvalid[g]),
      .o_bresp   (bank_b[g].resp),
      .i_bready  (bready),
      .i_araddr  (araddr),
      .i_arvalid (bank_arvalid[g]),
      .o_arready (bank_arready[g]),
      .o_rvalid  (bank_rvalid[g]),
      .o_rdata   (bank_r[g].data),
      .o_rresp   (bank_r[g].resp),
      .i_rready  (rready)
    );
  end

  // response merge, write and read
  axi_resp_select #(.payload_t(axi_sys_pkg::b_payload_t)) u_b_select (
    .i_valid   (bank_bvalid),
    .i_payload (bank_b),
    .o_valid   (bvalid),
    .o_payload (b_merged)
  );

  axi_resp_select #(.payload_t(axi_sys_pkg::r_payload_t)) u_r_select (
    .i_valid   (bank_rvalid),
    .i_payload (bank_r),
    .o_valid   (rvalid),
    .o_payload (r_merged)
  );

endmodule

`default_nettype wire

/* axi_resp_select.sv */
// one-hot merge of per-bank response channels; payload type set per instance
`timescale 1ns/10ps
`default_nettype none

module axi_resp_select #(
  parameter type payload_t = axi_sys_pkg::b_payload_t
) (
  input  wire      [axi_sys_pkg::NUM_BANKS-1:0] i_valid,
  input  payload_t [axi_sys_pkg::NUM_BANKS-1:0] i_payload,
  output logic                                  o_valid,
  output payload_t                              o_payload
);

  // at most one bank answers at a time
  always_comb begin
    o_payload = '0;
    for (int i = 0; i < axi_sys_pkg::NUM_BANKS; i++) begin
      if (i_valid[i]) o_payload = i_payload[i];
    end
  end

  assign o_valid = |i_valid;

endmodule

`default_nettype wire

/* axi_sram_bank.sv */
// single-beat AXI SRAM bank with byte strobes; instanced once per bank by the top level
`timescale 1ns/10ps
`default_nettype none

module axi_sram_bank (
  input  wire                                i_aclk,
  input  wire                                i_reset,
  input  wire  [axi_sys_pkg::ADDR_WIDTH-1:0] i_awaddr,
  input  wire                                i_awvalid,
  output logic                               o_awready,
  input  wire  [axi_sys_pkg::DATA_WIDTH-1:0] i_wdata,
  input  wire  [axi_sys_pkg::STRB_WIDTH-1:0] i_wstrb,
  input  wire                                i_wvalid,
  output logic                               o_wready,
  output logic                               o_bvalid,
  output logic [1:0]                         o_bresp,
  input  wire                                i_bready,
  input  wire  [axi_sys_pkg::ADDR_WIDTH-1:0] i_araddr,
  input  wire                                i_arvalid,
  output logic                               o_arready,
  output logic                               o_rvalid,
  output logic [axi_sys_pkg::DATA_WIDTH-1:0] o_rdata,
  output logic [1:0]                         o_rresp,
  input  wire                                i_rready
);

  logic [axi_sys_pkg::DATA_WIDTH-1:0]      mem [axi_sys_pkg::BANK_DEPTH];
  logic [axi_sys_pkg::BANK_ADDR_WIDTH-1:0] wr_idx;
  logic [axi_sys_pkg::BANK_ADDR_WIDTH-1:0] rd_idx;
  logic                                    wr_oor;  // write past the mapped range
  logic                                    rd_oor;

  assign wr_idx = i_awaddr[axi_sys_pkg::BANK_ADDR_LSB +: axi_sys_pkg::BANK_ADDR_WIDTH];
  assign rd_idx = i_araddr[axi_sys_pkg::BANK_ADDR_LSB +: axi_sys_pkg::BANK_ADDR_WIDTH];
  assign wr_oor = |i_awaddr[axi_sys_pkg::ADDR_WIDTH-1:axi_sys_pkg::MEM_ADDR_BITS];
  assign rd_oor = |i_araddr[axi_sys_pkg::ADDR_WIDTH-1:axi_sys_pkg::MEM_ADDR_BITS];

  // AW and W are taken together, only while no response is pending
  assign o_awready = !o_bvalid && i_awvalid && i_wvalid;
  assign o_wready  = o_awready;
  assign o_arready = !o_rvalid && i_arvalid;

  wire wr_fire = o_awready;  // implies both valids
  wire rd_fire = o_arready;

  // --------------------------------------------------
  // response valids
  // --------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if (wr_fire) o_bvalid <= 1'b1;
      else if (i_bready) o_bvalid <= 1'b0;
      if (rd_fire) o_rvalid <= 1'b1;
      else if (i_rready) o_rvalid <= 1'b0;
    end
  end

  // storage and response payloads
  always_ff @(posedge i_aclk) begin
    if (wr_fire) begin
      if (!wr_oor) begin
        for (int b = 0; b < axi_sys_pkg::STRB_WIDTH; b++) begin
          if (i_wstrb[b]) mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
      o_bresp <= wr_oor ? axi_sys_pkg::RESP_SLVERR : axi_sys_pkg::RESP_OKAY;
    end
    if (rd_fire) begin
      o_rdata <= rd_oor ? '0 : mem[rd_idx];  // zero data on error
      o_rresp <= rd_oor ? axi_sys_pkg::RESP_SLVERR : axi_sys_pkg::RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

/* axi_sys_pkg.sv */
// shared widths, bank map, response codes and payload structs; referenced by scoped name
`default_nettype none

package axi_sys_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;                      // one strobe per byte
  localparam int ADDR_WIDTH = 32;

  // --------------------------------------------------
  // bank geometry, interleaved on 64-bit words
  // --------------------------------------------------
  localparam int NUM_BANKS       = 4;
  localparam int BANK_SEL_LSB    = 3;                              // bank index at addr[4:3]
  localparam int BANK_SEL_WIDTH  = $clog2(NUM_BANKS);
  localparam int BANK_DEPTH      = 64;
  localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);
  localparam int BANK_ADDR_LSB   = BANK_SEL_LSB + BANK_SEL_WIDTH;  // word index at addr[10:5]
  localparam int MEM_BYTES       = 2048;
  localparam int MEM_ADDR_BITS   = $clog2(MEM_BYTES);              // any bit above this is out of range

  // --------------------------------------------------
  // response codes
  // --------------------------------------------------
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // read response payload
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
  } r_payload_t;

  // write response payload
  typedef struct packed {
    logic [1:0] resp;
  } b_payload_t;

endpackage

`default_nettype wire

/* tb_axi_mem_subsys.sv */
// self-checking testbench for the memory subsystem; reference byte model, LFSR traffic, asserts
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem_subsys;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_XFERS  = 256 + 2 + 3 + 16 + 3 + 200;  // fill plus all directed and random

  logic        i_aclk;
  logic        i_reset;
  logic        i_rw_req;
  logic        i_rw_wr;
  logic [31:0] i_rw_addr;
  logic [7:0]  i_rw_wstrb;
  logic [63:0] i_rw_wdata;
  wire         o_rw_addr_ok;
  wire         o_rw_data_ok;
  wire  [63:0] o_rw_rdata;
  wire         o_rw_err;

  logic [7:0]  ref_mem [2048];  // mapped bytes
  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          tests;

  axi_mem_subsys dut (
    .i_aclk       (i_aclk),
    .i_reset      (i_reset),
    .i_rw_req     (i_rw_req),
    .i_rw_wr      (i_rw_wr),
    .i_rw_addr    (i_rw_addr),
    .i_rw_wstrb   (i_rw_wstrb),
    .i_rw_wdata   (i_rw_wdata),
    .o_rw_addr_ok (o_rw_addr_ok),
    .o_rw_data_ok (o_rw_data_ok),
    .o_rw_rdata   (o_rw_rdata),
    .o_rw_err     (o_rw_err)
  );

  always #(CLK_PERIOD / 2) i_aclk = ~i_aclk;

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // galois step
      bits = {bits[62:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic void ref_write(input logic [31:0] addr, input logic [7:0] strb,
                                    input logic [63:0] data);
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) ref_mem[{addr[10:3], 3'(b)}] = data[8*b +: 8];
    end
  endfunction

  function automatic logic [63:0] ref_word(input logic [31:0] addr);
    logic [63:0] w;
    w = '0;
    for (int b = 0; b < 8; b++) w[8*b +: 8] = ref_mem[{addr[10:3], 3'(b)}];
    return w;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // one client request, returns response and cycles from accept to done
  task automatic do_xfer(input bit wr, input logic [31:0] addr, input logic [7:0] strb,
                         input logic [63:0] data, output logic [63:0] rdata,
                         output bit err, output int lat);
    @(negedge i_aclk);
    i_rw_req   = 1'b1;
    i_rw_wr    = wr;
    i_rw_addr  = addr;
    i_rw_wstrb = strb;
    i_rw_wdata = data;
    #1;
    while (!o_rw_addr_ok) begin
      @(negedge i_aclk);
      #1;
    end
    lat = 0;
    do begin
      @(negedge i_aclk);
      i_rw_req = 1'b0;
      lat++;
    end while (!o_rw_data_ok);
    rdata = o_rw_rdata;
    err   = o_rw_err;
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("test %-10s %s (%0d errors)", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin : main
    logic [63:0] rd;
    logic [63:0] tmp;
    logic [63:0] data;
    logic [31:0] addr;
    logic [7:0]  strb;
    bit          wr;
    bit          err;
    int          lat;
    int          err0;
    i_aclk     = 1'b0;
    i_reset    = 1'b1;
    i_rw_req   = 1'b0;
    i_rw_wr    = 1'b0;
    i_rw_addr  = '0;
    i_rw_wstrb = '0;
    i_rw_wdata = '0;
    lfsr       = 32'he39a;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    repeat (2) @(negedge i_aclk);
    i_reset = 1'b0;

    err0 = errors;
    repeat (4) begin
      @(negedge i_aclk);
      check_eq("idle addr_ok", 64'd0, 64'(o_rw_addr_ok));
      check_eq("idle data_ok", 64'd0, 64'(o_rw_data_ok));
    end
    end_test("reset", err0);

    // preload every word so reads never see unwritten storage
    err0 = errors;
    for (int w = 0; w < 256; w++) begin
      addr = 32'(w * 8);
      data = {addr ^ 32'h5a5a_0000, ~addr};
      ref_write(addr, 8'hff, data);
      do_xfer(1'b1, addr, 8'hff, data, rd, err, lat);
      check_eq("fill err", 64'd0, 64'(err));
    end
    end_test("fill", err0);

    err0 = errors;
    do_xfer(1'b1, 32'h1a8, 8'hff, 64'hdead_beef_cafe_f00d, rd, err, lat);
    ref_write(32'h1a8, 8'hff, 64'hdead_beef_cafe_f00d);
    check_eq("word write latency", 64'd2, 64'(lat));
    do_xfer(1'b0, 32'h1a8, 8'h00, 64'd0, rd, err, lat);
    check_eq("word read data", ref_word(32'h1a8), rd);
    check_eq("word read err", 64'd0, 64'(err));
    check_eq("word read latency", 64'd2, 64'(lat));
    end_test("word", err0);

    err0 = errors;
    do_xfer(1'b1, 32'h230, 8'hff, 64'h0123_4567_89ab_cdef, rd, err, lat);
    ref_write(32'h230, 8'hff, 64'h0123_4567_89ab_cdef);
    do_xfer(1'b1, 32'h230, 8'b1010_0101, 64'hffee_ddcc_bbaa_9988, rd, err, lat);
    ref_write(32'h230, 8'b1010_0101, 64'hffee_ddcc_bbaa_9988);
    do_xfer(1'b0, 32'h230, 8'h00, 64'd0, rd, err, lat);
    check_eq("strobe read data", ref_word(32'h230), rd);
    end_test("strobe", err0);

    // two passes over all four banks
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      addr = 32'h300 + 32'(i * 8);
      data = 64'h0101_0101_0101_0101 * 64'(i + 1);
      ref_write(addr, 8'hff, data);
      do_xfer(1'b1, addr, 8'hff, data, rd, err, lat);
    end
    for (int i = 0; i < 8; i++) begin
      addr = 32'h300 + 32'(i * 8);
      do_xfer(1'b0, addr, 8'h00, 64'd0, rd, err, lat);
      check_eq("interleave data", ref_word(addr), rd);
    end
    end_test("interleave", err0);

    err0 = errors;
    do_xfer(1'b1, 32'h848, 8'hff, 64'hbad0_bad0_bad0_bad0, rd, err, lat);
    check_eq("oor write err", 64'd1, 64'(err));
    do_xfer(1'b0, 32'h048, 8'h00, 64'd0, rd, err, lat);  // aliased word untouched
    check_eq("oor alias data", ref_word(32'h048), rd);
    do_xfer(1'b0, 32'h1000_0010, 8'h00, 64'd0, rd, err, lat);
    check_eq("oor read err", 64'd1, 64'(err));
    check_eq("oor read data", 64'd0, rd);
    end_test("range", err0);

    err0 = errors;
    for (int n = 0; n < 200; n++) begin
      tmp  = take_bits(1);
      wr   = tmp[0];
      tmp  = take_bits(8);
      addr = {21'd0, tmp[7:0], 3'd0};
      tmp  = take_bits(8);
      strb = tmp[7:0];
      data = take_bits(64);
      do_xfer(wr, addr, strb, data, rd, err, lat);
      if (wr) begin
        ref_write(addr, strb, data);
      end else begin
        check_eq("random read data", ref_word(addr), rd);
      end
      check_eq("random err", 64'd0, 64'(err));
    end
    end_test("random", err0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // generous bound of 10 cycles per transaction
  initial begin : watchdog
    #((NUM_XFERS * 10 + 50) * CLK_PERIOD);
    $display("watchdog expired before all transactions completed");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
axi_sys_pkg.sv
axi_master_bridge.sv
axi_bank_decoder.sv
axi_sram_bank.sv
axi_resp_select.sv
axi_mem_subsys.sv
tb_axi_mem_subsys.sv
